// ==== logic/knn_data_pkg.sv ====
// Payload widths for the k-NN core
// Labels are 4 bits wide, so at most 16 classes
// Vote counts are 8 bits wide, so K is limited to 255
package knn_data_pkg;

    // ========================================================
    // Field widths
    // ========================================================

    // Precomputed distance from the host side
    parameter int DIST_W = 16;

    // Class label of one training sample
    parameter int LABEL_W = 4;

    // Votes gathered by one class
    parameter int COUNT_W = 8;

    // ========================================================
    // Vector types
    // ========================================================

    // One distance on the stream or in a cell
    typedef logic [DIST_W-1:0] dist_t;

    // One class label
    typedef logic [LABEL_W-1:0] label_t;

    // Number of kept neighbours that carry one label
    typedef logic [COUNT_W-1:0] count_t;

endpackage

// ==== logic/knn_ctrl_pkg.sv ====
// State encodings for the frame controller and the vote unit
// Both FSMs reset into their idle state
package knn_ctrl_pkg;

    // Frame controller
    // IDLE waits for start, ACCEPT takes the stream
    // FLUSH lets the chain settle, WAIT_VOTE waits for the result
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        ACCEPT    = 2'd1,
        FLUSH     = 2'd2,
        WAIT_VOTE = 2'd3
    } frame_state_t;

    // Vote unit
    // Idle literal carries a prefix to stay apart from the frame IDLE
    typedef enum logic [1:0] {
        VOTE_IDLE = 2'd0,
        SCAN      = 2'd1,
        REPORT    = 2'd2
    } vote_state_t;

endpackage

// ==== logic/knn_insert_cell.sv ====
// One stage of the sorted k-best chain, at most one candidate per cycle
// Equal distances are ordered by arrival index, earlier sample ahead
module knn_insert_cell
    import knn_data_pkg::*;
#(
    parameter int SEQ_W = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,
    input  logic             in_valid,
    input  dist_t            in_dist,
    input  label_t           in_label,
    input  logic [SEQ_W-1:0] in_seq,
    output logic             out_valid,
    output dist_t            out_dist,
    output label_t           out_label,
    output logic [SEQ_W-1:0] out_seq,
    output logic             held_valid,
    output label_t           held_label
);

    dist_t            held_dist;
    logic [SEQ_W-1:0] held_seq;
    logic             cand_wins;
    logic             take_cand;

    // Strictly smaller distance, or same distance from an earlier sample
    // Displaced entries can arrive behind later equal ones
    assign cand_wins = (in_dist < held_dist) ||
                       ((in_dist == held_dist) && (in_seq < held_seq));

    // Empty cell always keeps the candidate
    assign take_cand = in_valid && (!held_valid || cand_wins);

    // Occupancy and outgoing strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else if (clear) begin
            held_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            if (in_valid) begin
                held_valid <= 1'b1;
            end
            // Something moves on only if this cell was already full
            out_valid <= in_valid && held_valid;
        end
    end

    // Kept entry and the entry passed to the next cell
    always_ff @(posedge clk) begin
        if (take_cand) begin
            held_dist  <= in_dist;
            held_label <= in_label;
            held_seq   <= in_seq;
        end
        if (in_valid) begin
            if (take_cand) begin
                // Old entry moves one place down
                out_dist  <= held_dist;
                out_label <= held_label;
                out_seq   <= held_seq;
            end else begin
                out_dist  <= in_dist;
                out_label <= in_label;
                out_seq   <= in_seq;
            end
        end
    end

endmodule

// ==== logic/knn_frame_ctrl.sv ====
// Accepts exactly NUM_SAMPLES beats per frame, then holds dist_ready low
// A start outside IDLE is ignored
module knn_frame_ctrl
    import knn_data_pkg::*;
    import knn_ctrl_pkg::*;
#(
    parameter int K           = 5,
    parameter int NUM_SAMPLES = 12,
    parameter int SEQ_W       = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic             dist_valid,
    input  dist_t            dist_data,
    input  label_t           dist_label,
    input  logic             result_valid,
    output logic             dist_ready,
    output logic             chain_clear,
    output logic             feed_valid,
    output dist_t            feed_dist,
    output label_t           feed_label,
    output logic [SEQ_W-1:0] feed_seq,
    output logic             vote_start
);

    // Flush counter runs 0..K, so K+1 cycles in FLUSH
    localparam int FLUSH_W = $clog2(K + 2);

    frame_state_t       state;
    logic [SEQ_W-1:0]   sample_cnt;
    logic [FLUSH_W-1:0] flush_cnt;
    logic               accept;
    logic               last_beat;
    logic               flush_done;

    // ========================================================
    // Handshake and decodes
    // ========================================================

    // Ready as a level for the whole open frame
    assign dist_ready = (state == ACCEPT);
    assign accept     = dist_valid && dist_ready;

    // Current beat is the NUM_SAMPLES-th one
    assign last_beat  = (sample_cnt == SEQ_W'(NUM_SAMPLES - 1));

    // Last candidate has left the final cell by now
    assign flush_done = (flush_cnt == FLUSH_W'(K));

    // Chain empties on the same edge that opens the frame
    assign chain_clear = (state == IDLE) && start;

    // ========================================================
    // Frame FSM
    // ========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            sample_cnt <= '0;
            flush_cnt  <= '0;
            feed_valid <= 1'b0;
            vote_start <= 1'b0;
        end else begin
            // Each accepted beat shows up on the feed one cycle later
            feed_valid <= accept;
            vote_start <= 1'b0;

            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= ACCEPT;
                        sample_cnt <= '0;
                    end
                end

                ACCEPT: begin
                    if (accept) begin
                        sample_cnt <= sample_cnt + 1'b1;
                        // Ready drops from the next cycle
                        if (last_beat) begin
                            state     <= FLUSH;
                            flush_cnt <= '0;
                        end
                    end
                end

                FLUSH: begin
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_done) begin
                        state      <= WAIT_VOTE;
                        vote_start <= 1'b1;
                    end
                end

                WAIT_VOTE: begin
                    // Result pulse closes the frame
                    if (result_valid) begin
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ========================================================
    // Feed register
    // ========================================================

    // Arrival index travels along as the tie breaker
    always_ff @(posedge clk) begin
        if (accept) begin
            feed_dist  <= dist_data;
            feed_label <= dist_label;
            feed_seq   <= sample_cnt;
        end
    end

endmodule

// ==== logic/knn_vote_tally.sv ====
// Scans one class per cycle, NUM_CLASSES cycles, then one REPORT cycle
// Labels at or above NUM_CLASSES are never counted
module knn_vote_tally
    import knn_data_pkg::*;
    import knn_ctrl_pkg::*;
#(
    parameter int K           = 5,
    parameter int NUM_CLASSES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 vote_start,
    input  logic [K-1:0]         cell_valid,
    input  logic [K*LABEL_W-1:0] cell_labels,
    output logic                 result_valid,
    output label_t               result_label,
    output count_t               result_count
);

    vote_state_t state;
    label_t      class_idx;
    count_t      class_votes;
    count_t      best_count;
    label_t      best_label;
    logic        last_class;

    assign last_class = (class_idx == label_t'(NUM_CLASSES - 1));

    // ========================================================
    // Votes for the class under scan
    // ========================================================

    // Only occupied cells vote
    always_comb begin
        class_votes = '0;
        for (int i = 0; i < K; i++) begin
            if (cell_valid[i] && (cell_labels[i*LABEL_W +: LABEL_W] == class_idx)) begin
                class_votes = class_votes + count_t'(1);
            end
        end
    end

    // ========================================================
    // Vote FSM
    // ========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= VOTE_IDLE;
            class_idx    <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;

            case (state)
                VOTE_IDLE: begin
                    if (vote_start) begin
                        state     <= SCAN;
                        class_idx <= '0;
                    end
                end

                SCAN: begin
                    class_idx <= class_idx + 1'b1;
                    if (last_class) begin
                        state <= REPORT;
                    end
                end

                REPORT: begin
                    // Single-cycle result strobe
                    result_valid <= 1'b1;
                    state        <= VOTE_IDLE;
                end

                default: begin
                    state <= VOTE_IDLE;
                end
            endcase
        end
    end

    // ========================================================
    // Running best and result registers
    // ========================================================
    always_ff @(posedge clk) begin
        case (state)
            VOTE_IDLE: begin
                if (vote_start) begin
                    best_count <= '0;
                    best_label <= '0;
                end
            end

            SCAN: begin
                // Strictly greater, so a tie stays with the lower label
                if (class_votes > best_count) begin
                    best_count <= class_votes;
                    best_label <= class_idx;
                end
            end

            REPORT: begin
                result_label <= best_label;
                result_count <= best_count;
            end

            default: begin
                best_count <= best_count;
            end
        endcase
    end

endmodule

// ==== logic/knn_classifier_top.sv ====
// NUM_SAMPLES must be at least K, NUM_CLASSES at most 16
// result_valid follows the last accepted beat by K + NUM_CLASSES + 3 cycles
module knn_classifier_top
    import knn_data_pkg::*;
#(
    parameter int K           = 5,
    parameter int NUM_SAMPLES = 12,
    parameter int NUM_CLASSES = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  logic   dist_valid,
    input  dist_t  dist_data,
    input  label_t dist_label,
    output logic   dist_ready,
    output logic   result_valid,
    output label_t result_label,
    output count_t result_count
);

    // Arrival index width, wide enough for NUM_SAMPLES
    localparam int SEQ_W = $clog2(NUM_SAMPLES + 1);

    logic chain_clear;
    logic vote_start;

    // Chain links, entry i feeds cell i
    // Entry K is what drops off the end
    logic [K:0]       chain_valid;
    dist_t            chain_dist  [0:K];
    label_t           chain_label [0:K];
    logic [SEQ_W-1:0] chain_seq   [0:K];

    // Kept neighbours towards the vote unit
    logic [K-1:0]         cell_valid;
    logic [K*LABEL_W-1:0] cell_labels;

    // ========================================================
    // Frame control
    // ========================================================
    knn_frame_ctrl #(
        .K           (K),
        .NUM_SAMPLES (NUM_SAMPLES),
        .SEQ_W       (SEQ_W)
    ) u_frame_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .dist_valid   (dist_valid),
        .dist_data    (dist_data),
        .dist_label   (dist_label),
        .result_valid (result_valid),
        .dist_ready   (dist_ready),
        .chain_clear  (chain_clear),
        .feed_valid   (chain_valid[0]),
        .feed_dist    (chain_dist[0]),
        .feed_label   (chain_label[0]),
        .feed_seq     (chain_seq[0]),
        .vote_start   (vote_start)
    );

    // ========================================================
    // Insertion chain, cell 0 holds the nearest neighbour
    // ========================================================
    for (genvar i = 0; i < K; i++) begin : g_cell
        knn_insert_cell #(
            .SEQ_W (SEQ_W)
        ) u_cell (
            .clk        (clk),
            .rst_n      (rst_n),
            .clear      (chain_clear),
            .in_valid   (chain_valid[i]),
            .in_dist    (chain_dist[i]),
            .in_label   (chain_label[i]),
            .in_seq     (chain_seq[i]),
            .out_valid  (chain_valid[i+1]),
            .out_dist   (chain_dist[i+1]),
            .out_label  (chain_label[i+1]),
            .out_seq    (chain_seq[i+1]),
            .held_valid (cell_valid[i]),
            .held_label (cell_labels[i*LABEL_W +: LABEL_W])
        );
    end

    // ========================================================
    // Majority vote
    // ========================================================
    knn_vote_tally #(
        .K           (K),
        .NUM_CLASSES (NUM_CLASSES)
    ) u_vote_tally (
        .clk          (clk),
        .rst_n        (rst_n),
        .vote_start   (vote_start),
        .cell_valid   (cell_valid),
        .cell_labels  (cell_labels),
        .result_valid (result_valid),
        .result_label (result_label),
        .result_count (result_count)
    );

endmodule

// ==== verif/knn_assertions.sv ====
// Control checks on the classifier top, attached with bind
// result_count is only checked while result_valid is high
module knn_assertions
    import knn_data_pkg::*;
    import knn_ctrl_pkg::*;
#(
    parameter int K = 5
) (
    input logic         clk,
    input logic         rst_n,
    input logic         start,
    input logic         dist_ready,
    input logic         result_valid,
    input count_t       result_count,
    input frame_state_t frame_state
);

    // Ready opens only on the cycle after a start seen in IDLE
    a_ready_after_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(dist_ready) |-> $past(start && (frame_state == IDLE))
    ) else $error("dist_ready rose without a start in IDLE");

    // Result strobe is a single-cycle pulse
    a_result_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid
    ) else $error("result_valid held for more than one cycle");

    // No class can collect more votes than kept neighbours
    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid |-> (result_count <= count_t'(K))
    ) else $error("result_count larger than K");

endmodule

bind knn_classifier_top knn_assertions #(
    .K (K)
) u_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .dist_ready   (dist_ready),
    .result_valid (result_valid),
    .result_count (result_count),
    .frame_state  (u_frame_ctrl.state)
);

// ==== verif/knn_tb.sv ====
// Self-checking testbench for the k-NN classifier core
// Local parameters must match the DUT instance below
module knn_tb
    import knn_data_pkg::*;
();

    localparam int K           = 5;
    localparam int NUM_SAMPLES = 12;
    localparam int NUM_CLASSES = 4;
    localparam int TIMEOUT     = 200;

    logic   clk = 1'b0;
    logic   rst_n;
    logic   start;
    logic   dist_valid;
    dist_t  dist_data;
    label_t dist_label;
    logic   dist_ready;
    logic   result_valid;
    label_t result_label;
    count_t result_count;

    // Current frame and the result the model expects for it
    dist_t       frame_dist  [NUM_SAMPLES];
    label_t      frame_label [NUM_SAMPLES];
    label_t      exp_label;
    count_t      exp_count;
    logic [31:0] rng_state;

    int frames_sent;
    int results_checked;
    int seq_errors;
    int check_errors;
    int tests_run;
    int tests_failed;

    knn_classifier_top #(
        .K           (K),
        .NUM_SAMPLES (NUM_SAMPLES),
        .NUM_CLASSES (NUM_CLASSES)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .dist_valid   (dist_valid),
        .dist_data    (dist_data),
        .dist_label   (dist_label),
        .dist_ready   (dist_ready),
        .result_valid (result_valid),
        .result_label (result_label),
        .result_count (result_count)
    );

    always #10 clk = ~clk;

    // ========================================================
    // Stimulus source and reference model
    // ========================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic void reference_vote(
        input  dist_t  d [NUM_SAMPLES],
        input  label_t l [NUM_SAMPLES],
        output label_t best_label,
        output count_t best_count
    );
        int votes [NUM_CLASSES];
        int rank;
        int i;
        int j;
        for (i = 0; i < NUM_CLASSES; i++) begin
            votes[i] = 0;
        end
        // Sample kept when fewer than K samples rank ahead of it
        for (i = 0; i < NUM_SAMPLES; i++) begin
            rank = 0;
            for (j = 0; j < NUM_SAMPLES; j++) begin
                if ((d[j] < d[i]) || ((d[j] == d[i]) && (j < i))) begin
                    rank++;
                end
            end
            if ((rank < K) && (int'(l[i]) < NUM_CLASSES)) begin
                votes[l[i]]++;
            end
        end
        // Lowest label keeps a tie
        best_label = '0;
        best_count = '0;
        for (i = 0; i < NUM_CLASSES; i++) begin
            if (votes[i] > int'(best_count)) begin
                best_count = count_t'(votes[i]);
                best_label = label_t'(i);
            end
        end
    endfunction

    // ========================================================
    // Result comparison
    // ========================================================
    always @(posedge clk) begin
        if (rst_n && result_valid) begin
            if (results_checked >= frames_sent) begin
                $display("ERROR t=%0t result_valid pulsed with no frame outstanding", $time);
                check_errors++;
            end else begin
                if (result_label !== exp_label) begin
                    $display("FAIL t=%0t result_label got %0d expected %0d",
                             $time, result_label, exp_label);
                    check_errors++;
                end
                if (result_count !== exp_count) begin
                    $display("FAIL t=%0t result_count got %0d expected %0d",
                             $time, result_count, exp_count);
                    check_errors++;
                end
            end
            results_checked++;
        end
    end

    // ========================================================
    // Driver tasks
    // ========================================================
    task automatic abort_on_timeout(input string what);
        $display("ERROR t=%0t timed out waiting for %s", $time, what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic check_quiet(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(posedge clk);
            if (dist_ready !== 1'b0) begin
                $display("FAIL t=%0t dist_ready got %b expected 0", $time, dist_ready);
                seq_errors++;
            end
            if (result_valid !== 1'b0) begin
                $display("FAIL t=%0t result_valid got %b expected 0", $time, result_valid);
                seq_errors++;
            end
        end
    endtask

    // Holds the beat until dist_ready is seen at an edge
    task automatic send_beat(input dist_t d, input label_t l);
        int waited;
        dist_valid <= 1'b1;
        dist_data  <= d;
        dist_label <= l;
        waited = 0;
        @(posedge clk);
        while (!dist_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_on_timeout("dist_ready");
            end
            @(posedge clk);
        end
    endtask

    // stray_beat below zero means no extra start inside the frame
    task automatic run_frame(input bit with_gaps, input int stray_beat);
        int i;
        int gap;
        reference_vote(frame_dist, frame_label, exp_label, exp_count);
        frames_sent++;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (i = 0; i < NUM_SAMPLES; i++) begin
            if (with_gaps) begin
                rng_state = xorshift32(rng_state);
                gap = int'(rng_state[1:0]);
                // Smallest distance on idle beats, harmful if taken
                dist_valid <= 1'b0;
                dist_data  <= '0;
                repeat (gap) @(posedge clk);
            end
            if (i == stray_beat) begin
                start <= 1'b1;
            end
            send_beat(frame_dist[i], frame_label[i]);
            start <= 1'b0;
        end
        dist_valid <= 1'b0;
    endtask

    task automatic wait_result();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!result_valid) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_on_timeout("result_valid");
            end
            @(posedge clk);
        end
        // Extra edge so the compare process has logged this pulse
        @(posedge clk);
    endtask

    task automatic fill_random_frame();
        int i;
        for (i = 0; i < NUM_SAMPLES; i++) begin
            rng_state = xorshift32(rng_state);
            // Narrow range makes equal distances common
            frame_dist[i]  = dist_t'(rng_state[13:8]);
            frame_label[i] = label_t'(int'(rng_state[31:24]) % NUM_CLASSES);
        end
    endtask

    task automatic fill_background(input int base, input int lbl);
        int i;
        for (i = 0; i < NUM_SAMPLES; i++) begin
            frame_dist[i]  = dist_t'(base + 10 * i);
            frame_label[i] = label_t'(lbl);
        end
    endtask

    function automatic void place_sample(input int idx, input int d, input int l);
        frame_dist[idx]  = dist_t'(d);
        frame_label[idx] = label_t'(l);
    endfunction

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (seq_errors + check_errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors",
                     tests_run, name, seq_errors + check_errors - errs_before);
        end
    endtask

    // ========================================================
    // Test sequence
    // ========================================================
    initial begin
        int errs;
        int n;
        rst_n           = 1'b0;
        start           = 1'b0;
        dist_valid      = 1'b0;
        dist_data       = '0;
        dist_label      = '0;
        rng_state       = 32'hdb5c;
        frames_sent     = 0;
        results_checked = 0;
        seq_errors      = 0;
        check_errors    = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        errs = seq_errors + check_errors;
        check_quiet(8);
        end_test("outputs quiet after reset", errs);

        errs = seq_errors + check_errors;
        fill_random_frame();
        run_frame(1'b0, -1);
        wait_result();
        end_test("random frame without gaps", errs);

        // Same data again, now with idle beats between samples
        errs = seq_errors + check_errors;
        run_frame(1'b1, -1);
        wait_result();
        end_test("same frame with valid gaps", errs);

        // Four samples at 100 straddle the fifth place
        errs = seq_errors + check_errors;
        fill_background(900, 2);
        place_sample(0, 50, 3);
        place_sample(2, 60, 1);
        place_sample(3, 100, 1);
        place_sample(5, 100, 1);
        place_sample(8, 100, 3);
        place_sample(10, 100, 3);
        run_frame(1'b0, -1);
        wait_result();
        end_test("equal distances at the k-th place", errs);

        // Classes 1 and 2 get two votes each
        errs = seq_errors + check_errors;
        fill_background(800, 0);
        place_sample(1, 20, 2);
        place_sample(0, 30, 2);
        place_sample(3, 40, 1);
        place_sample(4, 45, 1);
        place_sample(6, 50, 3);
        run_frame(1'b0, -1);
        wait_result();
        end_test("vote tie goes to lower label", errs);

        // First frame also sees start during ACCEPT and during FLUSH
        errs = seq_errors + check_errors;
        for (n = 0; n < 3; n++) begin
            fill_random_frame();
            run_frame(n == 1, (n == 0) ? 5 : -1);
            if (n == 0) begin
                start <= 1'b1;
                @(posedge clk);
                start <= 1'b0;
            end
            wait_result();
        end
        if (results_checked != frames_sent) begin
            $display("ERROR %0d frames sent but %0d results seen", frames_sent, results_checked);
            seq_errors++;
        end
        end_test("stray starts and back-to-back frames", errs);

        $display("Summary: %0d tests, %0d failed, %0d results compared, %0d errors",
                 tests_run, tests_failed, results_checked, seq_errors + check_errors);
        if ((tests_failed == 0) && (seq_errors + check_errors == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
logic/knn_data_pkg.sv
logic/knn_ctrl_pkg.sv
logic/knn_insert_cell.sv
logic/knn_frame_ctrl.sv
logic/knn_vote_tally.sv
logic/knn_classifier_top.sv
verif/knn_assertions.sv
verif/knn_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the k-NN testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log

rm -rf obj_dir "$LOG" "$BUILD_LOG"

# A failed build or a crashed run counts as a failing test
verilator --binary --timing --assert -Wno-fatal --top-module knn_tb \
    -f sources.f -o knn_sim > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/knn_sim > "$LOG" 2>&1 \
    || echo "Test failures found" >> "$LOG"

cat "$LOG"

grep -q "Test failures found" "$LOG" \
    && { echo "Simulation FAILED, see $LOG and $BUILD_LOG"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
